//--- logic/snake_defines.svh
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// ----------------------------------------------------------------------
// playfield geometry, in cells
// ----------------------------------------------------------------------
`define SNAKE_GRID_W          64
`define SNAKE_GRID_H          48
`define SNAKE_CELL_PX         10   // pixels per cell edge
`define SNAKE_BORDER          2    // ring thickness in cells

// snake and apple start state
`define SNAKE_MAX_LEN         16
`define SNAKE_START_LEN       3
`define SNAKE_START_X         32
`define SNAKE_START_Y         24
`define SNAKE_APPLE_X0        20
`define SNAKE_APPLE_Y0        20

// apple respawn counter
`define SNAKE_SPAWN_W         60
`define SNAKE_SPAWN_H         44
`define SNAKE_SPAWN_OFS       2

// timing and screen
`define SNAKE_DEBOUNCE_CYCLES 16   // clocks between button samples
`define SNAKE_SCREEN_W        640
`define SNAKE_SCREEN_H        480

`endif

//--- logic/snake_pkg.sv
package snake_pkg;

    // ----------------------------------------------------------------------
    // heading of the snake
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        DIR_NONE,   // after reset, snake stands still
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    // one grid cell
    typedef struct packed {
        logic [5:0] x;
        logic [5:0] y;
    } cell_t;

    // game state as seen from outside
    typedef struct packed {
        cell_t      head;
        cell_t      apple;
        logic [4:0] length;
        logic       game_over;
    } game_status_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } buttons_t;

    // 3-3-2 colour
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb_t;

    localparam rgb_t COLOR_BLACK  = '{r: 3'd0, g: 3'd0, b: 2'd0};
    localparam rgb_t COLOR_SNAKE  = '{r: 3'd0, g: 3'd7, b: 2'd0};
    localparam rgb_t COLOR_APPLE  = '{r: 3'd7, g: 3'd0, b: 2'd0};
    localparam rgb_t COLOR_BORDER = '{r: 3'd0, g: 3'd0, b: 2'd3};
    localparam rgb_t COLOR_DEAD   = '{r: 3'd7, g: 3'd7, b: 2'd3};

endpackage

//--- logic/button_debouncer.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module button_debouncer (
    input  logic in_clock,
    input  logic in_lethal,
    input  logic button,
    output logic press
);

    localparam int CNT_W = $clog2(`SNAKE_DEBOUNCE_CYCLES);

    logic [CNT_W-1:0] sample_count;
    logic             sample_en;
    logic [1:0]       samples;      // [0] newest, [1] previous

    assign sample_en = (sample_count == CNT_W'(`SNAKE_DEBOUNCE_CYCLES - 1));

    // ----------------------------------------------------------------------
    // sample strobe
    // ----------------------------------------------------------------------
    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            sample_count <= '0;
        end else begin
            sample_count <= sample_en ? '0 : sample_count + 1'b1;
        end
    end

    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            samples <= 2'b00;
        end else if (sample_en) begin
            samples <= {samples[0], button};
        end
    end

    // high on two samples in a row after a low one, one pulse per press
    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            press <= 1'b0;
        end else begin
            press <= sample_en & button & samples[0] & ~samples[1];
        end
    end

endmodule

//--- logic/direction_control.sv
`timescale 1ns/1ns

module direction_control (
    input  logic               in_clock,
    input  logic               in_lethal,
    input  snake_pkg::buttons_t buttons,
    output snake_pkg::dir_t    heading
);

    snake_pkg::buttons_t presses;   // one-cycle pulses, one per button

    button_debouncer u_deb_up (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .button    (buttons.up),
        .press     (presses.up)
    );

    button_debouncer u_deb_down (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .button    (buttons.down),
        .press     (presses.down)
    );

    button_debouncer u_deb_left (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .button    (buttons.left),
        .press     (presses.left)
    );

    button_debouncer u_deb_right (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .button    (buttons.right),
        .press     (presses.right)
    );

    // heading holds until the next press, up wins over the others
    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            heading <= snake_pkg::DIR_NONE;
        end else if (presses.up) begin
            heading <= snake_pkg::DIR_UP;
        end else if (presses.down) begin
            heading <= snake_pkg::DIR_DOWN;
        end else if (presses.left) begin
            heading <= snake_pkg::DIR_LEFT;
        end else if (presses.right) begin
            heading <= snake_pkg::DIR_RIGHT;
        end
    end

endmodule

//--- logic/snake_body.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module snake_body (
    input  logic                                  in_clock,
    input  logic                                  in_lethal,
    input  logic                                  step,
    input  snake_pkg::dir_t                       heading,
    input  snake_pkg::cell_t                      apple,
    output logic                                  advance,
    output logic                                  eat,
    output snake_pkg::cell_t [`SNAKE_MAX_LEN-1:0] segments,
    output snake_pkg::game_status_t               status
);

    localparam snake_pkg::cell_t START_CELL = '{x: 6'(`SNAKE_START_X),
                                                y: 6'(`SNAKE_START_Y)};

    snake_pkg::cell_t next_head;
    logic [4:0]       snake_len;
    logic             game_over;
    logic             hit_border;

    assign advance = step & ~game_over;   // steps are ignored once dead

    // ----------------------------------------------------------------------
    // next head cell and what it runs into
    // ----------------------------------------------------------------------
    always_comb begin
        next_head = segments[0];
        case (heading)
            snake_pkg::DIR_UP:    next_head.y = segments[0].y - 6'd1;
            snake_pkg::DIR_DOWN:  next_head.y = segments[0].y + 6'd1;
            snake_pkg::DIR_LEFT:  next_head.x = segments[0].x - 6'd1;
            snake_pkg::DIR_RIGHT: next_head.x = segments[0].x + 6'd1;
            default:              next_head   = segments[0];
        endcase
    end

    assign hit_border = (next_head.x < `SNAKE_BORDER) ||
                        (next_head.x >= `SNAKE_GRID_W - `SNAKE_BORDER) ||
                        (next_head.y < `SNAKE_BORDER) ||
                        (next_head.y >= `SNAKE_GRID_H - `SNAKE_BORDER);

    assign eat = advance && (next_head == apple);

    // ----------------------------------------------------------------------
    // body shift, length and game-over latch
    // ----------------------------------------------------------------------
    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
                segments[i] <= START_CELL;
            end
            snake_len <= 5'(`SNAKE_START_LEN);
            game_over <= 1'b0;
        end else if (advance) begin
            for (int i = `SNAKE_MAX_LEN - 1; i > 0; i--) begin
                segments[i] <= segments[i-1];
            end
            segments[0] <= next_head;
            if (eat && snake_len < 5'(`SNAKE_MAX_LEN)) begin
                snake_len <= snake_len + 5'd1;   // saturates at max length
            end
            if (hit_border) begin
                game_over <= 1'b1;
            end
        end
    end

    assign status = '{head:      segments[0],
                      apple:     apple,
                      length:    snake_len,
                      game_over: game_over};

endmodule

//--- logic/apple_spawner.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module apple_spawner (
    input  logic             in_clock,
    input  logic             in_lethal,
    input  logic             advance,
    input  logic             eat,
    output snake_pkg::cell_t apple
);

    logic [5:0] spawn_x;
    logic [5:0] spawn_y;
    logic [5:0] spawn_x_next;
    logic [5:0] spawn_y_next;

    // ----------------------------------------------------------------------
    // spawn counter, both axes step together
    // ----------------------------------------------------------------------
    assign spawn_x_next = (spawn_x == 6'(`SNAKE_SPAWN_W - 1)) ? 6'd0 : spawn_x + 6'd1;
    assign spawn_y_next = (spawn_y == 6'(`SNAKE_SPAWN_H - 1)) ? 6'd0 : spawn_y + 6'd1;

    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            spawn_x <= 6'd0;
            spawn_y <= 6'd0;
        end else if (advance) begin
            spawn_x <= spawn_x_next;
            spawn_y <= spawn_y_next;
        end
    end

    // new apple comes from the counter value before this step
    always_ff @(posedge in_clock or posedge in_lethal) begin
        if (in_lethal) begin
            apple.x <= 6'(`SNAKE_APPLE_X0);
            apple.y <= 6'(`SNAKE_APPLE_Y0);
        end else if (eat) begin
            apple.x <= spawn_x + 6'(`SNAKE_SPAWN_OFS);
            apple.y <= spawn_y + 6'(`SNAKE_SPAWN_OFS);
        end
    end

endmodule

//--- logic/pixel_renderer.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module pixel_renderer (
    input  logic [9:0]                            pixel_x,
    input  logic [8:0]                            pixel_y,
    input  snake_pkg::cell_t [`SNAKE_MAX_LEN-1:0] segments,
    input  snake_pkg::game_status_t               status,
    output snake_pkg::rgb_t                       color
);

    logic [9:0] cell_x;   // pixel position in cells
    logic [8:0] cell_y;
    logic       out_of_range;
    logic       on_border;
    logic       on_apple;
    logic       on_snake;

    assign cell_x = pixel_x / `SNAKE_CELL_PX;
    assign cell_y = pixel_y / `SNAKE_CELL_PX;

    // ----------------------------------------------------------------------
    // classify the pixel
    // ----------------------------------------------------------------------
    assign out_of_range = (pixel_x >= `SNAKE_SCREEN_W) || (pixel_y >= `SNAKE_SCREEN_H);

    assign on_border = (cell_x < `SNAKE_BORDER) ||
                       (cell_x >= `SNAKE_GRID_W - `SNAKE_BORDER) ||
                       (cell_y < `SNAKE_BORDER) ||
                       (cell_y >= `SNAKE_GRID_H - `SNAKE_BORDER);

    assign on_apple = (cell_x == {4'd0, status.apple.x}) &&
                      (cell_y == {3'd0, status.apple.y});

    // only the first length segments are live
    always_comb begin
        on_snake = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            if (i < status.length &&
                cell_x == {4'd0, segments[i].x} &&
                cell_y == {3'd0, segments[i].y}) begin
                on_snake = 1'b1;
            end
        end
    end

    // colour priority
    always_comb begin
        if (out_of_range) begin
            color = snake_pkg::COLOR_BLACK;
        end else if (status.game_over) begin
            color = snake_pkg::COLOR_DEAD;   // whole field goes white
        end else if (on_snake) begin
            color = snake_pkg::COLOR_SNAKE;
        end else if (on_apple) begin
            color = snake_pkg::COLOR_APPLE;
        end else if (on_border) begin
            color = snake_pkg::COLOR_BORDER;
        end else begin
            color = snake_pkg::COLOR_BLACK;
        end
    end

endmodule

//--- logic/snake_game.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module snake_game (
    input  logic                    in_clock,
    input  logic                    in_lethal,
    input  snake_pkg::buttons_t     buttons,
    input  logic                    step,       // one pulse per frame
    input  logic [9:0]              pixel_x,
    input  logic [8:0]              pixel_y,
    output snake_pkg::game_status_t status,
    output snake_pkg::rgb_t         color
);

    snake_pkg::dir_t                       heading;
    snake_pkg::cell_t                      apple;
    snake_pkg::cell_t [`SNAKE_MAX_LEN-1:0] segments;
    logic                                  advance;
    logic                                  eat;

    // ----------------------------------------------------------------------
    // input side
    // ----------------------------------------------------------------------
    direction_control u_direction (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .buttons   (buttons),
        .heading   (heading)
    );

    // game state
    snake_body u_body (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .step      (step),
        .heading   (heading),
        .apple     (apple),
        .advance   (advance),
        .eat       (eat),
        .segments  (segments),
        .status    (status)
    );

    apple_spawner u_apple (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .advance   (advance),
        .eat       (eat),
        .apple     (apple)
    );

    // output side
    pixel_renderer u_render (
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .segments  (segments),
        .status    (status),
        .color     (color)
    );

endmodule

//--- verif/snake_game_tb.sv
`timescale 1ns/1ns
`include "snake_defines.svh"

module snake_game_tb;

    typedef enum logic [1:0] {ROW_STEP, ROW_PRESS, ROW_TAP, ROW_QUERY} row_kind_t;

    // one table row, expected state after the action
    typedef struct packed {
        row_kind_t               kind;
        snake_pkg::buttons_t     btn;
        logic [5:0]              count;   // steps to issue
        logic [9:0]              px;
        logic [8:0]              py;
        snake_pkg::cell_t        head;
        logic [4:0]              length;
        logic                    game_over;
        snake_pkg::rgb_t         color;   // only for queries
    } row_t;

    localparam int NUM_ROWS    = 23;
    localparam int SAMPLE      = `SNAKE_DEBOUNCE_CYCLES;
    localparam int ROW_CYCLES  = 8 * SAMPLE + 16;   // a press is the costliest row
    localparam int WATCHDOG_NS = (NUM_ROWS * ROW_CYCLES + 100) * 8;

    localparam snake_pkg::buttons_t NO_BTN    = 4'b0000;
    localparam snake_pkg::buttons_t BTN_UP    = 4'b1000;
    localparam snake_pkg::buttons_t BTN_LEFT  = 4'b0010;
    localparam snake_pkg::buttons_t BTN_RIGHT = 4'b0001;

    logic                    in_clock;
    logic                    in_lethal;
    snake_pkg::buttons_t     buttons;
    logic                    step;
    logic [9:0]              pixel_x;
    logic [8:0]              pixel_y;
    snake_pkg::game_status_t status;
    snake_pkg::rgb_t         color;

    row_t                    rows [NUM_ROWS];
    snake_pkg::game_status_t want;

    // reference model state
    snake_pkg::cell_t        model_head;
    snake_pkg::cell_t        model_apple;
    snake_pkg::dir_t         model_heading;
    logic                    model_over;
    int                      spawn_x;
    int                      spawn_y;

    snake_game dut (
        .in_clock  (in_clock),
        .in_lethal (in_lethal),
        .buttons   (buttons),
        .step      (step),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .status    (status),
        .color     (color)
    );

    initial in_clock = 1'b0;
    always #4 in_clock = ~in_clock;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic row_t make_row(input row_kind_t kind, input snake_pkg::buttons_t btn,
                                      input int count, input int px, input int py,
                                      input int hx, input int hy, input int len,
                                      input int go, input snake_pkg::rgb_t col);
        row_t r;
        r.kind      = kind;
        r.btn       = btn;
        r.count     = 6'(count);
        r.px        = 10'(px);
        r.py        = 9'(py);
        r.head.x    = 6'(hx);
        r.head.y    = 6'(hy);
        r.length    = 5'(len);
        r.game_over = go[0];
        r.color     = col;
        return r;
    endfunction

    // one accepted step of the game rules
    task automatic model_step();
        snake_pkg::cell_t nxt;
        if (!model_over) begin
            nxt = model_head;
            case (model_heading)
                snake_pkg::DIR_UP:    nxt.y = nxt.y - 6'd1;
                snake_pkg::DIR_DOWN:  nxt.y = nxt.y + 6'd1;
                snake_pkg::DIR_LEFT:  nxt.x = nxt.x - 6'd1;
                snake_pkg::DIR_RIGHT: nxt.x = nxt.x + 6'd1;
                default:              nxt   = model_head;
            endcase
            if (nxt == model_apple) begin
                model_apple.x = 6'(spawn_x + `SNAKE_SPAWN_OFS);   // counter before the step
                model_apple.y = 6'(spawn_y + `SNAKE_SPAWN_OFS);
            end
            if (nxt.x < `SNAKE_BORDER || nxt.x >= `SNAKE_GRID_W - `SNAKE_BORDER ||
                nxt.y < `SNAKE_BORDER || nxt.y >= `SNAKE_GRID_H - `SNAKE_BORDER)
                model_over = 1'b1;
            model_head = nxt;
            spawn_x    = (spawn_x + 1) % `SNAKE_SPAWN_W;
            spawn_y    = (spawn_y + 1) % `SNAKE_SPAWN_H;
        end
    endtask

    task automatic run_steps(input int n);
        repeat (n) begin
            step = 1'b1;
            @(posedge in_clock);
            #1 step = 1'b0;
            model_step();
            @(posedge in_clock);
            #1;
        end
    endtask

    task automatic hold_button(input snake_pkg::buttons_t btn);
        buttons = btn;
        repeat (4 * SAMPLE) @(posedge in_clock);
        #1 buttons = NO_BTN;
        repeat (4 * SAMPLE) @(posedge in_clock);
        #1;
        if (btn.up)        model_heading = snake_pkg::DIR_UP;
        else if (btn.down) model_heading = snake_pkg::DIR_DOWN;
        else if (btn.left) model_heading = snake_pkg::DIR_LEFT;
        else if (btn.right) model_heading = snake_pkg::DIR_RIGHT;
    endtask

    // short tap that spans one sample strobe, gone before the next one
    task automatic tap_button(input snake_pkg::buttons_t btn);
        @(posedge in_clock);
        #1;
        while (dut.u_direction.u_deb_up.sample_count != SAMPLE - 2) begin
            @(posedge in_clock);
            #1;
        end
        buttons = btn;
        repeat (4) @(posedge in_clock);
        #1 buttons = NO_BTN;
        repeat (4 * SAMPLE) @(posedge in_clock);
        #1;
    endtask

    task automatic check_status(input snake_pkg::game_status_t got,
                                input snake_pkg::game_status_t exp);
        if (got.head != exp.head)
            abort_run($sformatf("Mismatch at %0t ns: head (%0d,%0d), expected (%0d,%0d)",
                                $time, got.head.x, got.head.y, exp.head.x, exp.head.y));
        if (got.apple != exp.apple)
            abort_run($sformatf("Mismatch at %0t ns: apple (%0d,%0d), expected (%0d,%0d)",
                                $time, got.apple.x, got.apple.y, exp.apple.x, exp.apple.y));
        if (got.length != exp.length)
            abort_run($sformatf("Mismatch at %0t ns: length %0d, expected %0d",
                                $time, got.length, exp.length));
        if (got.game_over != exp.game_over)
            abort_run($sformatf("Mismatch at %0t ns: game_over %0b, expected %0b",
                                $time, got.game_over, exp.game_over));
    endtask

    task automatic check_color(input snake_pkg::rgb_t got, input snake_pkg::rgb_t exp);
        if (got != exp)
            abort_run($sformatf("Mismatch at %0t ns: color %0d/%0d/%0d, expected %0d/%0d/%0d",
                                $time, got.r, got.g, got.b, exp.r, exp.g, exp.b));
    endtask

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------
    task automatic fill_table();
        rows[0]  = make_row(ROW_STEP, NO_BTN, 2, 0, 0, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[1]  = make_row(ROW_QUERY, NO_BTN, 0, 325, 245, 32, 24, 3, 0, snake_pkg::COLOR_SNAKE);
        rows[2]  = make_row(ROW_QUERY, NO_BTN, 0, 205, 205, 32, 24, 3, 0, snake_pkg::COLOR_APPLE);
        rows[3]  = make_row(ROW_QUERY, NO_BTN, 0, 5, 5, 32, 24, 3, 0, snake_pkg::COLOR_BORDER);
        rows[4]  = make_row(ROW_QUERY, NO_BTN, 0, 405, 105, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[5]  = make_row(ROW_QUERY, NO_BTN, 0, 700, 100, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[6]  = make_row(ROW_PRESS, BTN_RIGHT, 0, 0, 0, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[7]  = make_row(ROW_STEP, NO_BTN, 3, 0, 0, 35, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[8]  = make_row(ROW_PRESS, BTN_LEFT, 0, 0, 0, 35, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[9]  = make_row(ROW_STEP, NO_BTN, 2, 0, 0, 33, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[10] = make_row(ROW_TAP, BTN_UP, 0, 0, 0, 33, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[11] = make_row(ROW_STEP, NO_BTN, 1, 0, 0, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[12] = make_row(ROW_PRESS, BTN_UP, 0, 0, 0, 32, 24, 3, 0, snake_pkg::COLOR_BLACK);
        rows[13] = make_row(ROW_STEP, NO_BTN, 4, 0, 0, 32, 20, 3, 0, snake_pkg::COLOR_BLACK);
        rows[14] = make_row(ROW_PRESS, BTN_LEFT, 0, 0, 0, 32, 20, 3, 0, snake_pkg::COLOR_BLACK);
        rows[15] = make_row(ROW_STEP, NO_BTN, 12, 0, 0, 20, 20, 4, 0, snake_pkg::COLOR_BLACK);
        rows[16] = make_row(ROW_QUERY, NO_BTN, 0, 255, 255, 20, 20, 4, 0, snake_pkg::COLOR_APPLE);
        rows[17] = make_row(ROW_PRESS, BTN_UP, 0, 0, 0, 20, 20, 4, 0, snake_pkg::COLOR_BLACK);
        rows[18] = make_row(ROW_STEP, NO_BTN, 18, 0, 0, 20, 2, 4, 0, snake_pkg::COLOR_BLACK);
        rows[19] = make_row(ROW_STEP, NO_BTN, 1, 0, 0, 20, 1, 4, 1, snake_pkg::COLOR_BLACK);
        rows[20] = make_row(ROW_STEP, NO_BTN, 3, 0, 0, 20, 1, 4, 1, snake_pkg::COLOR_BLACK);
        rows[21] = make_row(ROW_QUERY, NO_BTN, 0, 405, 205, 20, 1, 4, 1, snake_pkg::COLOR_DEAD);
        rows[22] = make_row(ROW_QUERY, NO_BTN, 0, 700, 100, 20, 1, 4, 1, snake_pkg::COLOR_BLACK);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        abort_run("the run did not finish before the watchdog limit");
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        in_lethal     = 1'b1;
        buttons       = NO_BTN;
        step          = 1'b0;
        pixel_x       = '0;
        pixel_y       = '0;
        model_head.x  = 6'(`SNAKE_START_X);
        model_head.y  = 6'(`SNAKE_START_Y);
        model_apple.x = 6'(`SNAKE_APPLE_X0);
        model_apple.y = 6'(`SNAKE_APPLE_Y0);
        model_heading = snake_pkg::DIR_NONE;
        model_over    = 1'b0;
        spawn_x       = 0;
        spawn_y       = 0;
        fill_table();

        repeat (5) @(posedge in_clock);
        #1 in_lethal = 1'b0;

        // state straight out of reset
        want.head      = model_head;
        want.apple     = model_apple;
        want.length    = 5'(`SNAKE_START_LEN);
        want.game_over = model_over;
        check_status(status, want);

        for (int i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].kind)
                ROW_STEP:  run_steps(rows[i].count);
                ROW_PRESS: hold_button(rows[i].btn);
                ROW_TAP:   tap_button(rows[i].btn);
                default: begin
                    pixel_x = rows[i].px;
                    pixel_y = rows[i].py;
                    @(posedge in_clock);
                    #1;
                end
            endcase
            want.head      = rows[i].head;
            want.apple     = model_apple;   // apple only comes from the model
            want.length    = rows[i].length;
            want.game_over = rows[i].game_over;
            check_status(status, want);
            if (rows[i].kind == ROW_QUERY)
                check_color(color, rows[i].color);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- snake_game.f
+incdir+logic
logic/snake_pkg.sv
logic/button_debouncer.sv
logic/direction_control.sv
logic/snake_body.sv
logic/apple_spawner.sv
logic/pixel_renderer.sv
logic/snake_game.sv
verif/snake_game_tb.sv
